/* src/cnn_dims_pkg.sv */
`default_nettype none

package cnn_dims_pkg;

    // ====================
    // network geometry
    // ====================
    localparam int KSIZE  = 3;
    localparam int NCH    = 2;
    localparam int NCLASS = 4;
    localparam int POOL   = 2;

    // default frame size
    localparam int DEF_IMG_W = 8;
    localparam int DEF_IMG_H = 8;

    // ====================
    // data widths
    // ====================
    localparam int PIX_BW       = 8;
    localparam int W_BW         = 8;
    localparam int B_BW         = 16;
    localparam int CONV_ACC_BW  = 20;
    localparam int DENSE_ACC_BW = 24;

    // right shift applied after relu
    localparam int REQ_SHIFT = 6;

    // weight counts, dense assumes 9 pooled positions
    localparam int CONV_NW  = NCH * KSIZE * KSIZE;
    localparam int DENSE_NW = NCLASS * NCH * 9;

    typedef logic        [PIX_BW-1:0] pix_t;
    typedef logic signed [W_BW-1:0]   wgt_t;
    typedef logic signed [B_BW-1:0]   bias_t;

endpackage

`default_nettype wire

/* src/cnn_bus_pkg.sv */
`default_nettype none

package cnn_bus_pkg;
    import cnn_dims_pkg::*;

    // ====================
    // apb
    // ====================
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // bias sits in the low half
    typedef struct packed {
        logic [31-B_BW:0] unused;
        bias_t            b;
    } bias_word_t;

    // one register word, four weights or one bias
    typedef union packed {
        wgt_t [3:0] w;
        bias_word_t bias;
    } param_word_u;

    // word address map
    localparam logic [7:0] ADDR_CONV_W   = 8'd0;
    localparam logic [7:0] ADDR_CONV_B   = 8'd8;
    localparam logic [7:0] ADDR_DENSE_W  = 8'd16;
    localparam logic [7:0] ADDR_DENSE_B  = 8'd40;
    localparam logic [7:0] CONV_W_WORDS  = 8'((CONV_NW + 3) / 4);
    localparam logic [7:0] DENSE_W_WORDS = 8'((DENSE_NW + 3) / 4);

    // ====================
    // pixel streams
    // ====================
    typedef struct packed {
        logic                   valid;
        pix_t [KSIZE*KSIZE-1:0] px;
    } win_t;

    typedef struct packed {
        logic           valid;
        pix_t [NCH-1:0] ch;
    } fmap_t;

    typedef struct packed {
        logic [$clog2(NCLASS)-1:0]      cls;
        logic signed [DENSE_ACC_BW-1:0] score;
    } result_t;

endpackage

`default_nettype wire

/* src/cnn_param_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module cnn_param_regs
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire apb_req_t         i_apb,
    output apb_rsp_t              o_apb,
    output wgt_t  [CONV_NW-1:0]   o_conv_w,
    output bias_t [NCH-1:0]       o_conv_b,
    output wgt_t  [DENSE_NW-1:0]  o_dense_w,
    output bias_t [NCLASS-1:0]    o_dense_b
);
    param_word_u wr_word;
    param_word_u rd_word;
    logic        access;
    logic        sel_cw;
    logic        sel_cb;
    logic        sel_dw;
    logic        sel_db;
    logic        mapped;
    logic [7:0]  idx;

    assign access  = i_apb.psel & i_apb.penable;
    assign wr_word = i_apb.pwdata;

    // ====================
    // address decode
    // ====================
    always_comb begin
        sel_cw = (i_apb.paddr < ADDR_CONV_W + CONV_W_WORDS);
        sel_cb = (i_apb.paddr >= ADDR_CONV_B) && (i_apb.paddr < ADDR_CONV_B + 8'(NCH));
        sel_dw = (i_apb.paddr >= ADDR_DENSE_W) && (i_apb.paddr < ADDR_DENSE_W + DENSE_W_WORDS);
        sel_db = (i_apb.paddr >= ADDR_DENSE_B) && (i_apb.paddr < ADDR_DENSE_B + 8'(NCLASS));
        mapped = sel_cw | sel_cb | sel_dw | sel_db;
        // word offset inside the selected region
        if (sel_cb) begin
            idx = i_apb.paddr - ADDR_CONV_B;
        end else if (sel_dw) begin
            idx = i_apb.paddr - ADDR_DENSE_W;
        end else if (sel_db) begin
            idx = i_apb.paddr - ADDR_DENSE_B;
        end else begin
            idx = i_apb.paddr - ADDR_CONV_W;
        end
    end

    // readback mux, unused bytes stay 0
    always_comb begin
        rd_word = '0;
        for (int k = 0; k < 4; k++) begin
            if (sel_cw && (int'(idx) * 4 + k < CONV_NW)) begin
                rd_word.w[k] = o_conv_w[int'(idx) * 4 + k];
            end else if (sel_dw) begin
                rd_word.w[k] = o_dense_w[int'(idx) * 4 + k];
            end
        end
        if (sel_cb) begin
            rd_word.bias.b = o_conv_b[idx];
        end
        if (sel_db) begin
            rd_word.bias.b = o_dense_b[idx];
        end
    end

    // single wait-free access phase
    always_comb begin
        o_apb.pready  = access;
        o_apb.pslverr = access & ~mapped;
        o_apb.prdata  = (access & ~i_apb.pwrite) ? rd_word : '0;
    end

    // ====================
    // parameter storage
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_conv_w  <= '0;
            o_conv_b  <= '0;
            o_dense_w <= '0;
            o_dense_b <= '0;
        end else if (access && i_apb.pwrite) begin
            for (int k = 0; k < 4; k++) begin
                if (sel_cw && (int'(idx) * 4 + k < CONV_NW)) begin
                    o_conv_w[int'(idx) * 4 + k] <= wr_word.w[k];
                end
                if (sel_dw) begin
                    o_dense_w[int'(idx) * 4 + k] <= wr_word.w[k];
                end
            end
            if (sel_cb) begin
                o_conv_b[idx] <= wr_word.bias.b;
            end
            if (sel_db) begin
                o_dense_b[idx] <= wr_word.bias.b;
            end
        end
    end

endmodule

`default_nettype wire

/* src/window_feeder.sv */
`default_nettype none
`timescale 1ns/1ps

module window_feeder
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
#(
    parameter int IMG_W = DEF_IMG_W,
    parameter int IMG_H = DEF_IMG_H
) (
    input  wire       clk,
    input  wire       reset_n,
    input  wire       i_pix_valid,
    input  wire pix_t i_pix,
    output win_t      o_win
);
    localparam int CW = $clog2(IMG_W);
    localparam int RW = $clog2(IMG_H);

    logic [CW-1:0]          col;
    logic [RW-1:0]          row;
    pix_t                   lb_mid [IMG_W];
    pix_t                   lb_top [IMG_W];
    pix_t [KSIZE*KSIZE-1:0] win_px;
    logic                   win_vld;

    // ====================
    // raster position
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col     <= '0;
            row     <= '0;
            win_vld <= 1'b0;
        end else begin
            // full neighborhood once two rows and two columns are behind
            win_vld <= i_pix_valid && (col >= CW'(KSIZE - 1)) && (row >= RW'(KSIZE - 1));
            if (i_pix_valid) begin
                if (col == CW'(IMG_W - 1)) begin
                    col <= '0;
                    row <= (row == RW'(IMG_H - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // two previous rows, one entry per column
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < IMG_W; i++) begin
                lb_mid[i] <= '0;
                lb_top[i] <= '0;
            end
        end else if (i_pix_valid) begin
            lb_top[col] <= lb_mid[col];
            lb_mid[col] <= i_pix;
        end
    end

    // shift window left, new column enters on the right
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int k = 0; k < KSIZE - 1; k++) begin
                    win_px[r*KSIZE + k] <= win_px[r*KSIZE + k + 1];
                end
            end
            win_px[KSIZE - 1]       <= lb_top[col];
            win_px[2*KSIZE - 1]     <= lb_mid[col];
            win_px[KSIZE*KSIZE - 1] <= i_pix;
        end
    end

    assign o_win = {win_vld, win_px};

endmodule

`default_nettype wire

/* src/conv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module conv_core
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire win_t                 i_win,
    input  wire wgt_t  [CONV_NW-1:0]  i_weight,
    input  wire bias_t [NCH-1:0]      i_bias,
    output fmap_t                     o_fmap
);
    localparam int KN      = KSIZE * KSIZE;
    localparam int PROD_BW = PIX_BW + W_BW + 1;
    // smallest accumulator value that saturates after the shift
    localparam int SAT_LIM = (1 << PIX_BW) << REQ_SHIFT;

    logic signed [PROD_BW-1:0]     prod_q [NCH][KN];
    logic                          prod_vld;
    logic signed [CONV_ACC_BW-1:0] acc    [NCH];
    pix_t [NCH-1:0]                req;
    pix_t [NCH-1:0]                out_q;
    logic                          out_vld;

    // ====================
    // stage 1: products
    // ====================
    always_ff @(posedge clk) begin
        for (int c = 0; c < NCH; c++) begin
            for (int k = 0; k < KN; k++) begin
                // pixel is unsigned, widen before the signed multiply
                prod_q[c][k] <= $signed({1'b0, i_win.px[k]}) * i_weight[c*KN + k];
            end
        end
    end

    // ====================
    // stage 2: sum, relu, requantize
    // ====================
    always_comb begin
        for (int c = 0; c < NCH; c++) begin
            acc[c] = i_bias[c];
            for (int k = 0; k < KN; k++) begin
                acc[c] = acc[c] + prod_q[c][k];
            end
            if (acc[c] < 0) begin
                req[c] = '0;
            end else if (acc[c] >= SAT_LIM) begin
                req[c] = '1;
            end else begin
                req[c] = acc[c][REQ_SHIFT +: PIX_BW];
            end
        end
    end

    always_ff @(posedge clk) begin
        out_q <= req;
    end

    // valid follows the data through both stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_vld <= 1'b0;
            out_vld  <= 1'b0;
        end else begin
            prod_vld <= i_win.valid;
            out_vld  <= prod_vld;
        end
    end

    assign o_fmap = {out_vld, out_q};

endmodule

`default_nettype wire

/* src/max_pool.sv */
`default_nettype none
`timescale 1ns/1ps

module max_pool
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
#(
    parameter int IMG_W = DEF_IMG_W,
    parameter int IMG_H = DEF_IMG_H
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire fmap_t i_fmap,
    output fmap_t      o_fmap
);
    // convolution output size
    localparam int OW = IMG_W - KSIZE + 1;
    localparam int OH = IMG_H - KSIZE + 1;
    localparam int HW = OW / POOL;
    localparam int CW = $clog2(OW);
    localparam int RW = $clog2(OH);

    logic [CW-1:0]  col;
    logic [RW-1:0]  row;
    pix_t [NCH-1:0] prev;
    pix_t [NCH-1:0] pair;
    pix_t [NCH-1:0] hbuf [HW];
    pix_t [NCH-1:0] out_q;
    logic           out_vld;

    function automatic pix_t max2(input pix_t a, input pix_t b);
        return (a > b) ? a : b;
    endfunction

    // horizontal max of the current column pair
    always_comb begin
        for (int c = 0; c < NCH; c++) begin
            pair[c] = max2(prev[c], i_fmap.ch[c]);
        end
    end

    // ====================
    // position in the map
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col     <= '0;
            row     <= '0;
            out_vld <= 1'b0;
        end else begin
            out_vld <= i_fmap.valid && col[0] && row[0];
            if (i_fmap.valid) begin
                if (col == CW'(OW - 1)) begin
                    col <= '0;
                    row <= (row == RW'(OH - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // even row fills the half-row buffer, odd row finishes the block
    always_ff @(posedge clk) begin
        if (i_fmap.valid) begin
            if (!col[0]) begin
                prev <= i_fmap.ch;
            end else if (!row[0]) begin
                hbuf[col / POOL] <= pair;
            end else begin
                for (int c = 0; c < NCH; c++) begin
                    out_q[c] <= max2(hbuf[col / POOL][c], pair[c]);
                end
            end
        end
    end

    assign o_fmap = {out_vld, out_q};

endmodule

`default_nettype wire

/* src/dense_classifier.sv */
`default_nettype none
`timescale 1ns/1ps

module dense_classifier
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
#(
    parameter int IMG_W = DEF_IMG_W,
    parameter int IMG_H = DEF_IMG_H
) (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire fmap_t                 i_fmap,
    input  wire wgt_t  [DENSE_NW-1:0]  i_weight,
    input  wire bias_t [NCLASS-1:0]    i_bias,
    output logic                       o_result_valid,
    output result_t                    o_result
);
    // pooled positions per frame
    localparam int NP     = ((IMG_W - KSIZE + 1) / POOL) * ((IMG_H - KSIZE + 1) / POOL);
    localparam int PW     = $clog2(NP);
    localparam int CLS_BW = $clog2(NCLASS);

    logic [PW-1:0]                  p_cnt;
    logic                           last;
    logic signed [DENSE_ACC_BW-1:0] acc    [NCLASS];
    logic signed [DENSE_ACC_BW-1:0] acc_nx [NCLASS];
    logic signed [DENSE_ACC_BW-1:0] fin    [NCLASS];
    logic [CLS_BW-1:0]              best_cls;
    logic signed [DENSE_ACC_BW-1:0] best_score;

    assign last = i_fmap.valid && (p_cnt == PW'(NP - 1));

    // ====================
    // accumulate and argmax
    // ====================
    always_comb begin
        for (int cl = 0; cl < NCLASS; cl++) begin
            acc_nx[cl] = acc[cl];
            for (int ch = 0; ch < NCH; ch++) begin
                acc_nx[cl] = acc_nx[cl] + $signed({1'b0, i_fmap.ch[ch]})
                           * i_weight[(cl*NCH + ch)*NP + p_cnt];
            end
            fin[cl] = acc_nx[cl] + i_bias[cl];
        end
        // strict compare keeps the lowest index on a tie
        best_cls   = '0;
        best_score = fin[0];
        for (int cl = 1; cl < NCLASS; cl++) begin
            if (fin[cl] > best_score) begin
                best_cls   = CLS_BW'(cl);
                best_score = fin[cl];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_cnt          <= '0;
            o_result_valid <= 1'b0;
            for (int cl = 0; cl < NCLASS; cl++) begin
                acc[cl] <= '0;
            end
        end else begin
            o_result_valid <= last;
            if (i_fmap.valid) begin
                p_cnt <= last ? '0 : p_cnt + 1'b1;
                // clear at end of frame for the next one
                for (int cl = 0; cl < NCLASS; cl++) begin
                    acc[cl] <= last ? '0 : acc_nx[cl];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last) begin
            o_result.cls   <= best_cls;
            o_result.score <= best_score;
        end
    end

endmodule

`default_nettype wire

/* src/cnn_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cnn_top
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
#(
    parameter int IMG_W = DEF_IMG_W,
    parameter int IMG_H = DEF_IMG_H
) (
    input  wire           clk,
    input  wire           reset_n,
    input  wire apb_req_t i_apb,
    output apb_rsp_t      o_apb,
    input  wire           i_pix_valid,
    input  wire pix_t     i_pix,
    output logic          o_result_valid,
    output result_t       o_result
);
    wgt_t  [CONV_NW-1:0]  conv_w;
    bias_t [NCH-1:0]      conv_b;
    wgt_t  [DENSE_NW-1:0] dense_w;
    bias_t [NCLASS-1:0]   dense_b;
    win_t                 win;
    fmap_t                conv_fmap;
    fmap_t                pool_fmap;

    // ====================
    // parameter bank
    // ====================
    cnn_param_regs u_param_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_apb     (i_apb),
        .o_apb     (o_apb),
        .o_conv_w  (conv_w),
        .o_conv_b  (conv_b),
        .o_dense_w (dense_w),
        .o_dense_b (dense_b)
    );

    // ====================
    // pixel pipeline
    // ====================
    window_feeder #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_window_feeder (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win       (win)
    );

    conv_core u_conv_core (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_win    (win),
        .i_weight (conv_w),
        .i_bias   (conv_b),
        .o_fmap   (conv_fmap)
    );

    max_pool #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_max_pool (
        .clk     (clk),
        .reset_n (reset_n),
        .i_fmap  (conv_fmap),
        .o_fmap  (pool_fmap)
    );

    // scores four classes once per frame
    dense_classifier #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_dense_classifier (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_fmap         (pool_fmap),
        .i_weight       (dense_w),
        .i_bias         (dense_b),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

endmodule

`default_nettype wire

/* test/tb_cnn_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_cnn_top
    import cnn_dims_pkg::*;
    import cnn_bus_pkg::*;
();
    localparam int IMG_W          = 8;
    localparam int IMG_H          = 8;
    localparam int OW             = IMG_W - 2;
    localparam int NPOOL          = 9;
    localparam int LATENCY        = 5;
    localparam int RESULT_WAIT    = 100;
    localparam int TIMEOUT_CYCLES = 20000;

    logic     clk;
    logic     reset_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     pix_valid;
    pix_t     pix;
    logic     result_valid;
    result_t  result;

    int          errors = 0;
    int          cycle = 0;
    int          last_pix_cycle;
    int unsigned seed = 11;

    // captured results
    logic [1:0]  res_cls_q   [$];
    logic [23:0] res_score_q [$];
    int          res_cyc_q   [$];

    // expected parameter contents and frames
    wgt_t  cw [CONV_NW];
    bias_t cb [NCH];
    wgt_t  dw [DENSE_NW];
    bias_t db [NCLASS];
    pix_t  frames [3][IMG_W*IMG_H];

    cnn_top #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_apb          (apb_req),
        .o_apb          (apb_rsp),
        .i_pix_valid    (pix_valid),
        .i_pix          (pix),
        .o_result_valid (result_valid),
        .o_result       (result)
    );

    always #10 clk = ~clk;

    // cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycle);
            $display("sim failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (reset_n && result_valid) begin
            res_cls_q.push_back(result.cls);
            res_score_q.push_back(result.score);
            res_cyc_q.push_back(cycle);
        end
    end

    // ====================
    // helpers
    // ====================
    function automatic int unsigned lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 16;
    endfunction

    function automatic wgt_t small_wgt();
        return 8'(int'(lcg_next() % 25) - 12);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("error: %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    function automatic logic is_mapped(input logic [7:0] addr);
        return (addr < 5) || (addr >= 8 && addr < 10) || (addr >= 16 && addr < 34)
            || (addr >= 40 && addr < 44);
    endfunction

    function automatic logic is_bias(input logic [7:0] addr);
        return (addr >= 8 && addr < 10) || (addr >= 40 && addr < 44);
    endfunction

    // register word as the host should see it
    function automatic logic [31:0] pack_word(input logic [7:0] addr);
        logic [31:0] w;
        int          i;
        w = '0;
        if (addr < 5) begin
            for (int k = 0; k < 4; k++) begin
                i = int'(addr) * 4 + k;
                if (i < CONV_NW) begin
                    w[k*8 +: 8] = cw[i];
                end
            end
        end else if (addr >= 8 && addr < 10) begin
            w[15:0] = cb[addr - 8];
        end else if (addr >= 16 && addr < 34) begin
            for (int k = 0; k < 4; k++) begin
                w[k*8 +: 8] = dw[(int'(addr) - 16) * 4 + k];
            end
        end else if (addr >= 40 && addr < 44) begin
            w[15:0] = db[addr - 40];
        end
        return w;
    endfunction

    function automatic void unpack_word(input logic [7:0] addr, input logic [31:0] w);
        int i;
        if (addr < 5) begin
            for (int k = 0; k < 4; k++) begin
                i = int'(addr) * 4 + k;
                if (i < CONV_NW) begin
                    cw[i] = w[k*8 +: 8];
                end
            end
        end else if (addr >= 8 && addr < 10) begin
            cb[addr - 8] = w[15:0];
        end else if (addr >= 16 && addr < 34) begin
            for (int k = 0; k < 4; k++) begin
                dw[(int'(addr) - 16) * 4 + k] = w[k*8 +: 8];
            end
        end else if (addr >= 40 && addr < 44) begin
            db[addr - 40] = w[15:0];
        end
    endfunction

    // unused bits get random filler
    function automatic logic [31:0] make_word(input logic [7:0] addr);
        logic [31:0] w;
        if (is_bias(addr)) begin
            w[31:16] = 16'(lcg_next());
            w[15:0]  = 16'(int'(lcg_next() % 512) - 256);
        end else begin
            for (int k = 0; k < 4; k++) begin
                w[k*8 +: 8] = small_wgt();
            end
            if (addr == 4) begin
                w[31:16] = 16'(lcg_next());
            end
        end
        return w;
    endfunction

    function automatic void gen_frame(input int f);
        for (int i = 0; i < IMG_W*IMG_H; i++) begin
            frames[f][i] = 8'(lcg_next());
        end
    endfunction

    // ====================
    // reference model
    // ====================
    function automatic void model(input int f, output int cls, output int score);
        int conv   [NCH][OW*OW];
        int pooled [NCH][NPOOL];
        int sc     [NCLASS];
        int acc;
        int v;
        for (int ch = 0; ch < NCH; ch++) begin
            for (int r = 0; r < OW; r++) begin
                for (int c = 0; c < OW; c++) begin
                    acc = int'(cb[ch]);
                    for (int dr = 0; dr < 3; dr++) begin
                        for (int dc = 0; dc < 3; dc++) begin
                            acc += int'(frames[f][(r + dr) * IMG_W + c + dc])
                                 * int'(cw[ch*9 + dr*3 + dc]);
                        end
                    end
                    v = (acc < 0) ? 0 : (acc >>> REQ_SHIFT);
                    conv[ch][r*OW + c] = (v > 255) ? 255 : v;
                end
            end
            // 2x2 max over the 6x6 map
            for (int pr = 0; pr < 3; pr++) begin
                for (int pc = 0; pc < 3; pc++) begin
                    v = 0;
                    for (int i = 0; i < 2; i++) begin
                        for (int j = 0; j < 2; j++) begin
                            if (conv[ch][(2*pr + i)*OW + 2*pc + j] > v) begin
                                v = conv[ch][(2*pr + i)*OW + 2*pc + j];
                            end
                        end
                    end
                    pooled[ch][pr*3 + pc] = v;
                end
            end
        end
        for (int cl = 0; cl < NCLASS; cl++) begin
            sc[cl] = int'(db[cl]);
            for (int p = 0; p < NPOOL; p++) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    sc[cl] += pooled[ch][p] * int'(dw[(cl*NCH + ch)*9 + p]);
                end
            end
        end
        cls   = 0;
        score = sc[0];
        for (int cl = 1; cl < NCLASS; cl++) begin
            if (sc[cl] > score) begin
                cls   = cl;
                score = sc[cl];
            end
        end
    endfunction

    // ====================
    // bus and stream tasks
    // ====================
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        // sample in the middle of the access phase
        @(negedge clk);
        check("o_apb.pready", 32'd1, 32'(apb_rsp.pready));
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic write_params();
        logic err;
        for (int a = 0; a < 64; a++) begin
            if (is_mapped(8'(a))) begin
                apb_write(8'(a), pack_word(8'(a)), err);
                check("o_apb.pslverr", 32'd0, 32'(err));
            end
        end
    endtask

    task automatic verify_params();
        logic [31:0] data;
        logic        err;
        for (int a = 0; a < 64; a++) begin
            if (is_mapped(8'(a))) begin
                apb_read(8'(a), data, err);
                check($sformatf("o_apb.prdata @%0d", a), pack_word(8'(a)), data);
                check("o_apb.pslverr", 32'd0, 32'(err));
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            pix_valid = 1'b0;
        end
    endtask

    // valid stays high after the last pixel until the caller idles
    task automatic send_frame(input int f, input bit with_gaps);
        int gap;
        for (int i = 0; i < IMG_W*IMG_H; i++) begin
            gap = 0;
            if (with_gaps && (lcg_next() % 3 == 0)) begin
                gap = 1 + int'(lcg_next() % 4);
            end
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                #1;
                pix_valid = 1'b0;
                pix       = 8'(lcg_next());
            end
            @(posedge clk);
            #1;
            pix_valid = 1'b1;
            pix       = frames[f][i];
        end
        last_pix_cycle = cycle;
    endtask

    task automatic wait_results(input int n);
        int guard;
        guard = 0;
        while (res_cls_q.size() < n && guard < RESULT_WAIT) begin
            @(posedge clk);
            guard++;
        end
        if (res_cls_q.size() < n) begin
            $display("no classifier result arrived within %0d cycles", RESULT_WAIT);
            errors++;
        end
    endtask

    task automatic compare_result(input int idx, input int f, input bit timed,
                                  input int exp_cycle);
        int exp_cls;
        int exp_score;
        if (idx < res_cls_q.size()) begin
            model(f, exp_cls, exp_score);
            check("o_result.cls", 32'(exp_cls), 32'(res_cls_q[idx]));
            check("o_result.score", 32'(exp_score) & 32'hff_ffff, 32'(res_score_q[idx]));
            if (timed) begin
                check("o_result_valid cycle", 32'(exp_cycle), 32'(res_cyc_q[idx]));
            end
        end
    endtask

    task automatic expect_count(input int n);
        idle(20);
        if (res_cls_q.size() != n) begin
            $display("expected %0d classifier results in total, counted %0d",
                     n, res_cls_q.size());
            errors++;
        end
    endtask

    // ====================
    // tests
    // ====================
    task automatic reset_state();
        check("o_result_valid", 32'd0, 32'(result_valid));
        check("o_apb.pslverr", 32'd0, 32'(apb_rsp.pslverr));
        check("o_apb.pready", 32'd0, 32'(apb_rsp.pready));
        verify_params();
    endtask

    task automatic param_readback();
        logic [31:0] w;
        logic        err;
        for (int a = 0; a < 64; a++) begin
            if (is_mapped(8'(a))) begin
                w = make_word(8'(a));
                apb_write(8'(a), w, err);
                unpack_word(8'(a), w);
            end
        end
        verify_params();
    endtask

    task automatic unmapped_access();
        logic [7:0]  bad [8] = '{8'd5, 8'd7, 8'd10, 8'd15, 8'd34, 8'd39, 8'd44, 8'd200};
        logic [31:0] data;
        logic        err;
        foreach (bad[i]) begin
            apb_write(bad[i], 32'(lcg_next()) << 16 | 32'(lcg_next()), err);
            check("o_apb.pslverr", 32'd1, 32'(err));
            apb_read(bad[i], data, err);
            check("o_apb.prdata", 32'd0, data);
            check("o_apb.pslverr", 32'd1, 32'(err));
            @(negedge clk);
            check("o_apb.pslverr", 32'd0, 32'(apb_rsp.pslverr));
        end
        verify_params();
    endtask

    task automatic classify_frame();
        int base;
        base = res_cls_q.size();
        gen_frame(0);
        send_frame(0, 1'b0);
        idle(1);
        wait_results(base + 1);
        compare_result(base, 0, 1'b1, last_pix_cycle + LATENCY);
        expect_count(base + 1);
    endtask

    // classes 1 and 2 share weights and bias while 0 and 3 score far below
    task automatic tie_break();
        int base;
        int v;
        for (int ch = 0; ch < NCH; ch++) begin
            for (int p = 0; p < NPOOL; p++) begin
                v = int'(lcg_next() % 8);
                dw[(0*NCH + ch)*9 + p] = 8'(-v - 1);
                dw[(1*NCH + ch)*9 + p] = 8'(v);
                dw[(2*NCH + ch)*9 + p] = 8'(v);
                dw[(3*NCH + ch)*9 + p] = 8'(-v - 1);
            end
        end
        db[0] = -16'sd3000;
        db[1] = 16'sd100;
        db[2] = 16'sd100;
        db[3] = -16'sd3000;
        write_params();
        base = res_cls_q.size();
        gen_frame(0);
        send_frame(0, 1'b0);
        idle(1);
        wait_results(base + 1);
        if (base < res_cls_q.size()) begin
            check("o_result.cls", 32'd1, 32'(res_cls_q[base]));
        end
        compare_result(base, 0, 1'b1, last_pix_cycle + LATENCY);
        expect_count(base + 1);
    endtask

    task automatic stream_frames();
        int base;
        int last1;
        int last2;
        base = res_cls_q.size();
        for (int f = 0; f < 3; f++) begin
            gen_frame(f);
        end
        send_frame(0, 1'b1);
        idle(10);
        // frames 1 and 2 back to back
        send_frame(1, 1'b0);
        last1 = last_pix_cycle;
        send_frame(2, 1'b0);
        last2 = last_pix_cycle;
        idle(1);
        wait_results(base + 3);
        compare_result(base, 0, 1'b0, 0);
        compare_result(base + 1, 1, 1'b1, last1 + LATENCY);
        compare_result(base + 2, 2, 1'b1, last2 + LATENCY);
        expect_count(base + 3);
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        apb_req   = '0;
        pix_valid = 1'b0;
        pix       = '0;
        foreach (cw[i]) begin
            cw[i] = '0;
        end
        foreach (cb[i]) begin
            cb[i] = '0;
        end
        foreach (dw[i]) begin
            dw[i] = '0;
        end
        foreach (db[i]) begin
            db[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        reset_state();
        param_readback();
        unmapped_access();
        classify_frame();
        tie_break();
        stream_frames();
        idle(5);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cnn_top.f */
src/cnn_dims_pkg.sv
src/cnn_bus_pkg.sv
src/cnn_param_regs.sv
src/window_feeder.sv
src/conv_core.sv
src/max_pool.sv
src/dense_classifier.sv
src/cnn_top.sv
test/tb_cnn_top.sv
